/* files.f */
design/dbg_pkg.sv
design/baud_timer.sv
design/uart_rx.sv
design/uart_tx.sv
design/cmd_decoder.sv
design/reply_sender.sv
design/debug_top.sv
sim/debug_top_properties.sv
sim/tb_debug_top.sv

/* Bender.yml */
package:
  name: debug_uart_port

sources:
  - design/dbg_pkg.sv
  - design/baud_timer.sv
  - design/uart_rx.sv
  - design/uart_tx.sv
  - design/cmd_decoder.sv
  - design/reply_sender.sv
  - design/debug_top.sv
  - target: simulation
    files:
      - sim/debug_top_properties.sv
      - sim/tb_debug_top.sv

/* sim/tb_debug_top.sv */
`timescale 1ns/10ps

module tb_debug_top;
    import dbg_pkg::*;

    localparam int    CLK_FREQ       = 25_000_000;
    localparam int    UART_BPS       = 2_500_000;
    localparam int    BIT_CYCLES     = CLK_FREQ / UART_BPS;
    localparam int    TIMEOUT_CYCLES = 20000;
    localparam word_t RF_BASE        = 32'h1357_9bdf;

    logic     sys_clk;
    logic     sys_rst_n;
    logic     uart_rxd;
    pc_t      debug_wb_pc;
    logic     ws_valid;
    word_t    rf_rdata;
    logic     break_point;
    logic     reg_rd_en;
    reg_idx_t reg_num;
    logic     uart_txd;

    logic [31:0] rng_state;
    int          cycle_cnt;
    int          rd_pulses;
    reg_idx_t    rd_last_num;

    debug_top #(
        .CLK_FREQ (CLK_FREQ),
        .UART_BPS (UART_BPS)
    ) u_dut (.*);

    always #20 sys_clk = ~sys_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // register file contents behind the debug port
    function automatic word_t rf_value(input reg_idx_t idx);
        return word_t'(idx) * 32'h0101_0101 + RF_BASE;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp)
        else fail_run($sformatf("ERROR %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic set_core(input pc_t pc, input logic valid);
        @(posedge sys_clk);
        #2;
        debug_wb_pc = pc;
        ws_valid    = valid;
    endtask

    task automatic expect_bp(input logic exp);
        @(negedge sys_clk);
        expect_equal("break_point", break_point, exp);
    endtask

    // host side of the line, 8N1, each bit starts 2 ns after an edge
    task automatic uart_send(input uart_byte_t data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        @(posedge sys_clk);
        for (int i = 0; i < 10; i++) begin
            #2;
            uart_rxd = frame[i];
            repeat (BIT_CYCLES) @(posedge sys_clk);
        end
        #2;
    endtask

    task automatic send_break(input pc_t addr);
        uart_send(CMD_BREAK);
        for (int k = 3; k >= 0; k--) begin
            uart_send(addr[8*k +: 8]);
        end
    endtask

    // reply bytes sampled mid-bit, msb byte first
    task automatic expect_reply(input word_t exp);
        uart_byte_t got;
        for (int k = REPLY_BYTES - 1; k >= 0; k--) begin
            @(negedge uart_txd);
            repeat (BIT_CYCLES / 2) @(posedge sys_clk);
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CYCLES) @(posedge sys_clk);
                #1;
                got[i] = uart_txd;
            end
            expect_equal("uart_txd reply byte", got, exp[8*k +: 8]);
        end
    endtask

    task automatic expect_line_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge sys_clk);
            expect_equal("uart_txd", uart_txd, 1'b1);
        end
    endtask

    always @(negedge sys_clk) begin
        if (reg_rd_en === 1'b1) begin
            rd_pulses++;
            rd_last_num = reg_num;
        end
    end

    always @(posedge sys_clk) begin
        #2;
        if (!$isunknown(reg_num)) begin
            rf_rdata = rf_value(reg_num);
        end
    end

    always @(posedge sys_clk) begin
        cycle_cnt++;
        if (u_dut.u_props.fail_count != 0) begin
            fail_run("a bound property on debug_top failed");
        end else if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run("timeout: the run did not finish within the cycle limit");
        end
    end

    initial begin
        pc_t        addr;
        pc_t        pc_hold;
        uart_byte_t idx_byte;
        reg_idx_t   idx_exp;
        int         pulses_before;

        sys_clk     = 1'b0;
        sys_rst_n   = 1'b0;
        uart_rxd    = 1'b1;
        debug_wb_pc = '0;
        ws_valid    = 1'b0;
        rf_rdata    = '0;
        rng_state   = 32'he34a_7d92;
        repeat (8) @(posedge sys_clk);
        #2;
        sys_rst_n = 1'b1;

        expect_line_quiet(2 * BIT_CYCLES);
        expect_equal("break_point", break_point, 1'b0);
        expect_equal("reg_rd_en", reg_rd_en, 1'b0);

        // breakpoint hits only on a valid matching pc
        rng_state = xorshift32(rng_state);
        addr = rng_state;
        send_break(addr);
        set_core(addr, 1'b1);
        expect_bp(1'b1);
        set_core(addr, 1'b0);
        expect_bp(1'b0);
        set_core(addr + 32'd4, 1'b1);
        expect_bp(1'b0);
        set_core(addr, 1'b1);
        expect_bp(1'b1);
        uart_send(CMD_CONTINUE);
        expect_bp(1'b0);

        rng_state = xorshift32(rng_state);
        pc_hold = rng_state;
        set_core(pc_hold, 1'b1);
        uart_send(CMD_STEP);
        expect_bp(1'b0);
        set_core(pc_hold + 32'd4, 1'b1);
        expect_bp(1'b1);
        uart_send(CMD_CONTINUE);
        expect_bp(1'b0);

        repeat (2) begin
            rng_state = xorshift32(rng_state);
            idx_byte = rng_state[7:0];
            idx_exp = reg_idx_t'(idx_byte % 32);
            pulses_before = rd_pulses;
            fork
                begin
                    uart_send(CMD_REG_READ);
                    uart_send(idx_byte);
                end
                expect_reply(rf_value(idx_exp));
            join
            expect_equal("reg_rd_en pulses", rd_pulses - pulses_before, 1);
            expect_equal("reg_num", rd_last_num, idx_exp);
        end

        rng_state = xorshift32(rng_state);
        pc_hold = rng_state;
        set_core(pc_hold, 1'b0);
        fork
            uart_send(CMD_LIST);
            expect_reply(pc_hold);
        join

        // unknown code with a breakpoint armed and hit
        rng_state = xorshift32(rng_state);
        addr = rng_state;
        send_break(addr);
        set_core(addr, 1'b1);
        expect_bp(1'b1);
        uart_send(8'h05);
        expect_line_quiet(30 * BIT_CYCLES);
        expect_bp(1'b1);
        uart_send(CMD_CONTINUE);
        expect_bp(1'b0);

        if (u_dut.u_props.fail_count != 0) begin
            fail_run("a bound property on debug_top failed");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

/* sim/debug_top_properties.sv */
`timescale 1ns/10ps

module debug_top_properties (
    input logic sys_clk,
    input logic sys_rst_n,
    input logic uart_txd,
    input logic tx_busy,
    input logic tx_start,
    input logic reg_rd_en
);

    int fail_count = 0;

    // line rests at the stop level between frames
    a_txd_idle_high: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        !tx_busy |-> uart_txd
    ) else begin
        fail_count++;
        $error("uart_txd low while the transmitter is idle");
    end

    a_rd_single: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        reg_rd_en |=> !reg_rd_en
    ) else begin
        fail_count++;
        $error("reg_rd_en high for more than one cycle");
    end

    // sender must wait for the transmitter
    a_start_when_free: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        tx_start |-> !tx_busy
    ) else begin
        fail_count++;
        $error("tx_start issued while tx_busy is high");
    end

endmodule

bind debug_top debug_top_properties u_props (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .uart_txd  (uart_txd),
    .tx_busy   (tx_busy),
    .tx_start  (tx_start),
    .reg_rd_en (reg_rd_en)
);

/* design/debug_top.sv */
`timescale 1ns/10ps

module debug_top #(
    parameter int CLK_FREQ = 50_000_000,
    parameter int UART_BPS = 9600
) (
    input  logic              sys_clk,
    input  logic              sys_rst_n,
    input  logic              uart_rxd,
    input  dbg_pkg::pc_t      debug_wb_pc,
    input  logic              ws_valid,
    input  dbg_pkg::word_t    rf_rdata,
    output logic              break_point,
    output logic              reg_rd_en,
    output dbg_pkg::reg_idx_t reg_num,
    output logic              uart_txd
);
    import dbg_pkg::*;

    logic       rx_done;
    uart_byte_t rx_data;
    logic       reply_load;
    word_t      reply_word;
    logic       tx_start;
    uart_byte_t tx_data;
    logic       tx_busy;

    uart_rx #(
        .CLK_FREQ (CLK_FREQ),
        .UART_BPS (UART_BPS)
    ) u_uart_rx (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .uart_rxd  (uart_rxd),
        .rx_done   (rx_done),
        .rx_data   (rx_data)
    );

    cmd_decoder u_cmd_decoder (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .rx_done     (rx_done),
        .rx_data     (rx_data),
        .debug_wb_pc (debug_wb_pc),
        .ws_valid    (ws_valid),
        .rf_rdata    (rf_rdata),
        .break_point (break_point),
        .reg_rd_en   (reg_rd_en),
        .reg_num     (reg_num),
        .reply_load  (reply_load),
        .reply_word  (reply_word)
    );

    reply_sender u_reply_sender (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .reply_load (reply_load),
        .reply_word (reply_word),
        .tx_busy    (tx_busy),
        .tx_start   (tx_start),
        .tx_data    (tx_data)
    );

    uart_tx #(
        .CLK_FREQ (CLK_FREQ),
        .UART_BPS (UART_BPS)
    ) u_uart_tx (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .tx_start  (tx_start),
        .tx_data   (tx_data),
        .tx_busy   (tx_busy),
        .uart_txd  (uart_txd)
    );

endmodule

/* design/reply_sender.sv */
`timescale 1ns/10ps

module reply_sender (
    input  logic                sys_clk,
    input  logic                sys_rst_n,
    input  logic                reply_load,
    input  dbg_pkg::word_t      reply_word,
    input  logic                tx_busy,
    output logic                tx_start,
    output dbg_pkg::uart_byte_t tx_data
);
    import dbg_pkg::*;

    localparam int CNT_W  = (REPLY_BYTES > 1) ? $clog2(REPLY_BYTES) : 1;
    localparam int BYTE_W = $bits(uart_byte_t);
    localparam int WORD_W = $bits(word_t);

    word_t            shift_word;
    logic [CNT_W-1:0] byte_cnt;
    logic             active;
    logic             send_now;

    // tx_busy only rises the cycle after tx_start, so hold off one cycle
    assign send_now = active && !tx_busy && !tx_start;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            active   <= 1'b0;
            byte_cnt <= '0;
            tx_start <= 1'b0;
        end else begin
            tx_start <= send_now;
            if (!active) begin
                if (reply_load) begin
                    active   <= 1'b1;
                    byte_cnt <= '0;
                end
            end else if (send_now) begin
                byte_cnt <= byte_cnt + 1'b1;
                if (byte_cnt == CNT_W'(REPLY_BYTES - 1)) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // top byte goes out first
    always_ff @(posedge sys_clk) begin
        if (!active && reply_load) begin
            shift_word <= reply_word;
        end else if (send_now) begin
            tx_data    <= shift_word[WORD_W-1 -: BYTE_W];
            shift_word <= shift_word << BYTE_W;
        end
    end

endmodule

/* design/cmd_decoder.sv */
`timescale 1ns/10ps

module cmd_decoder (
    input  logic                sys_clk,
    input  logic                sys_rst_n,
    input  logic                rx_done,
    input  dbg_pkg::uart_byte_t rx_data,
    input  dbg_pkg::pc_t        debug_wb_pc,
    input  logic                ws_valid,
    input  dbg_pkg::word_t      rf_rdata,
    output logic                break_point,
    output logic                reg_rd_en,
    output dbg_pkg::reg_idx_t   reg_num,
    output logic                reply_load,
    output dbg_pkg::word_t      reply_word
);
    import dbg_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        BREAK_ADDR,
        REG_IDX,
        REG_READ,
        REPLY
    } state_t;

    state_t      state;
    logic [1:0]  byte_cnt;
    logic [23:0] addr_buf;
    logic        break_armed;
    pc_t         break_pc;
    logic        step_armed;
    pc_t         step_pc;
    logic        cmd_valid;
    logic        addr_last;

    assign cmd_valid = (state == IDLE) && rx_done;
    assign addr_last = (state == BREAK_ADDR) && rx_done && (byte_cnt == 2'd3);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state       <= IDLE;
            byte_cnt    <= 2'd0;
            break_armed <= 1'b0;
            step_armed  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (rx_done) begin
                        case (rx_data)
                            CMD_BREAK: begin
                                state    <= BREAK_ADDR;
                                byte_cnt <= 2'd0;
                            end
                            CMD_CONTINUE: begin
                                break_armed <= 1'b0;
                                step_armed  <= 1'b0;
                            end
                            CMD_STEP: begin
                                step_armed  <= 1'b1;
                                break_armed <= 1'b0;
                            end
                            CMD_REG_READ: state <= REG_IDX;
                            CMD_LIST:     state <= REPLY;
                            default: ;
                        endcase
                    end
                end
                BREAK_ADDR: begin
                    if (rx_done) begin
                        byte_cnt <= byte_cnt + 2'd1;
                    end
                    if (addr_last) begin
                        break_armed <= 1'b1;
                        step_armed  <= 1'b0;
                        state       <= IDLE;
                    end
                end
                REG_IDX: begin
                    if (rx_done) begin
                        state <= REG_READ;
                    end
                end
                REG_READ: state <= REPLY;
                REPLY:    state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    // address arrives msb first
    always_ff @(posedge sys_clk) begin
        if ((state == BREAK_ADDR) && rx_done) begin
            addr_buf <= {addr_buf[15:0], rx_data};
        end
        if (addr_last) begin
            break_pc <= {addr_buf, rx_data};
        end
        if (cmd_valid && rx_data == CMD_STEP) begin
            step_pc <= debug_wb_pc;
        end
        if (cmd_valid && rx_data == CMD_LIST) begin
            reply_word <= debug_wb_pc;
        end
        if ((state == REG_IDX) && rx_done) begin
            reg_num <= rx_data[$bits(reg_idx_t)-1:0];
        end
        if (state == REG_READ) begin
            reply_word <= rf_rdata;
        end
    end

    assign reg_rd_en  = (state == REG_READ);
    assign reply_load = (state == REPLY);

    // step halts as soon as the pc moves off the captured one
    assign break_point = (break_armed && ws_valid && (debug_wb_pc == break_pc))
                      || (step_armed && (debug_wb_pc != step_pc));

endmodule

/* design/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx #(
    parameter int CLK_FREQ = 50_000_000,
    parameter int UART_BPS = 9600
) (
    input  logic                sys_clk,
    input  logic                sys_rst_n,
    input  logic                tx_start,
    input  dbg_pkg::uart_byte_t tx_data,
    output logic                tx_busy,
    output logic                uart_txd
);
    import dbg_pkg::*;

    localparam int BAUD_DIV = CLK_FREQ / UART_BPS;

    logic [3:0] bit_cnt;
    logic       bit_tick;
    uart_byte_t shift_reg;

    baud_timer #(
        .BAUD_DIV (BAUD_DIV)
    ) u_baud_timer (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .run       (tx_busy),
        .mid_tick  (),
        .bit_tick  (bit_tick)
    );

    // bit_cnt 0 is the start bit, 9 the stop bit
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            tx_busy  <= 1'b0;
            bit_cnt  <= 4'd0;
            uart_txd <= 1'b1;
        end else if (!tx_busy) begin
            if (tx_start) begin
                tx_busy  <= 1'b1;
                bit_cnt  <= 4'd0;
                uart_txd <= 1'b0;
            end
        end else if (bit_tick) begin
            if (bit_cnt == 4'd9) begin
                tx_busy <= 1'b0;
                bit_cnt <= 4'd0;
            end else begin
                uart_txd <= shift_reg[0];
                bit_cnt  <= bit_cnt + 4'd1;
            end
        end
    end

    // ones shift in behind the data and form the stop bit
    always_ff @(posedge sys_clk) begin
        if (!tx_busy && tx_start) begin
            shift_reg <= tx_data;
        end else if (tx_busy && bit_tick) begin
            shift_reg <= {1'b1, shift_reg[7:1]};
        end
    end

endmodule

/* design/uart_rx.sv */
`timescale 1ns/10ps

module uart_rx #(
    parameter int CLK_FREQ = 50_000_000,
    parameter int UART_BPS = 9600
) (
    input  logic                sys_clk,
    input  logic                sys_rst_n,
    input  logic                uart_rxd,
    output logic                rx_done,
    output dbg_pkg::uart_byte_t rx_data
);
    import dbg_pkg::*;

    localparam int BAUD_DIV = CLK_FREQ / UART_BPS;

    logic       rxd_s0;
    logic       rxd_s1;
    logic       rxd_s2;
    logic       start_edge;
    logic       rx_busy;
    logic [3:0] bit_cnt;
    logic       mid_tick;
    logic       bit_tick;
    uart_byte_t shift_reg;

    // two stages against metastability, the third for edge detect
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rxd_s0 <= 1'b1;
            rxd_s1 <= 1'b1;
            rxd_s2 <= 1'b1;
        end else begin
            rxd_s0 <= uart_rxd;
            rxd_s1 <= rxd_s0;
            rxd_s2 <= rxd_s1;
        end
    end

    assign start_edge = rxd_s2 && !rxd_s1 && !rx_busy;

    baud_timer #(
        .BAUD_DIV (BAUD_DIV)
    ) u_baud_timer (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .run       (rx_busy),
        .mid_tick  (mid_tick),
        .bit_tick  (bit_tick)
    );

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            rx_busy <= 1'b0;
            bit_cnt <= 4'd0;
            rx_done <= 1'b0;
        end else begin
            rx_done <= 1'b0;
            if (start_edge) begin
                rx_busy <= 1'b1;
                bit_cnt <= 4'd0;
            end else if (rx_busy) begin
                if (mid_tick && bit_cnt == 4'd0 && rxd_s1) begin
                    // line back high at mid start bit, just a glitch
                    rx_busy <= 1'b0;
                end else if (mid_tick && bit_cnt == 4'd9) begin
                    rx_busy <= 1'b0;
                    bit_cnt <= 4'd0;
                    rx_done <= 1'b1;
                end else if (bit_tick) begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
        end
    end

    // lsb arrives first
    always_ff @(posedge sys_clk) begin
        if (mid_tick && bit_cnt >= 4'd1 && bit_cnt <= 4'd8) begin
            shift_reg <= {rxd_s1, shift_reg[7:1]};
        end
        if (mid_tick && bit_cnt == 4'd9) begin
            rx_data <= shift_reg;
        end
    end

endmodule

/* design/baud_timer.sv */
`timescale 1ns/10ps

module baud_timer #(
    parameter int BAUD_DIV = 5208
) (
    input  logic sys_clk,
    input  logic sys_rst_n,
    input  logic run,
    output logic mid_tick,
    output logic bit_tick
);

    localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

    logic [CNT_W-1:0] cnt;

    // held at zero between frames
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cnt <= '0;
        end else if (!run) begin
            cnt <= '0;
        end else if (cnt == CNT_W'(BAUD_DIV - 1)) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign mid_tick = run && (cnt == CNT_W'(BAUD_DIV / 2));
    assign bit_tick = run && (cnt == CNT_W'(BAUD_DIV - 1));

endmodule

/* design/dbg_pkg.sv */
package dbg_pkg;

    // one serial data byte
    typedef logic [7:0]  uart_byte_t;

    // writeback pc, also used for breakpoint addresses
    typedef logic [31:0] pc_t;

    // reply payload
    typedef logic [31:0] word_t;

    // register file index
    typedef logic [4:0]  reg_idx_t;

    // host command codes
    localparam uart_byte_t CMD_BREAK    = 8'h02;
    localparam uart_byte_t CMD_CONTINUE = 8'h03;
    localparam uart_byte_t CMD_REG_READ = 8'h04;
    localparam uart_byte_t CMD_STEP     = 8'h06;
    localparam uart_byte_t CMD_LIST     = 8'h07;

    // bytes per reply, msb first
    localparam int REPLY_BYTES = 4;

endpackage
